// ==== hw/nnPkg.sv ====
package nnPkg;

	// ----------------------------------------
	// activations and layer vectors
	// ----------------------------------------
	typedef logic signed [15:0] act_t; // signed fixed point, wraps on overflow.

	localparam int NumIn = 10;
	localparam int NumHidden = 4;
	localparam int NumOut = 2;

	typedef act_t [NumIn-1:0] inVec_t;
	typedef act_t [NumHidden-1:0] hidVec_t;
	typedef act_t [NumOut-1:0] outVec_t;

	typedef struct packed {
		logic valid;
		inVec_t data; // narrower layers use the low slots.
	} layerIo_t;

	typedef struct packed {
		logic done; // bit1.
		logic busy; // bit0.
	} nnStatus_t;

	// ----------------------------------------
	// register map
	// ----------------------------------------
	localparam logic [7:0] InBase = 8'h00;
	localparam logic [7:0] CtrlAddr = 8'h28;
	localparam logic [7:0] StatusAddr = 8'h2C;
	localparam logic [7:0] OutBase = 8'h30;

	// default weights, one row per neuron
	localparam act_t [0:NumHidden-1][0:NumIn-1] HiddenWeights = '{
		'{12, -7, 31, 4, -18, 9, 27, -3, 15, -22},
		'{-9, 20, 5, -30, 11, 17, -6, 24, -13, 8},
		'{25, 14, -19, 7, 3, -26, 10, 18, -4, 21},
		'{-16, 6, 13, 22, -11, 2, -28, 9, 30, -5}
	};
	localparam act_t [0:NumHidden-1] HiddenBias = '{3, -12, 7, -4};
	localparam act_t [0:NumOut-1][0:NumHidden-1] OutWeights = '{
		'{14, -9, 21, 6},
		'{-11, 17, 5, -8}
	};
	localparam act_t [0:NumOut-1] OutBias = '{-6, 10};

endpackage

// ==== hw/neuronNode.sv ====
`timescale 1ns/1ps

module neuronNode #(
	parameter int NumInputs = 10,
	parameter nnPkg::act_t [0:NumInputs-1] Weights = '0,
	parameter nnPkg::act_t Bias = '0
) (
	input logic clk,
	input logic reset,
	input nnPkg::act_t [NumInputs-1:0] inputs,
	output nnPkg::act_t activation
);
	import nnPkg::*;

	act_t [NumInputs-1:0] inReg;
	act_t sumReg;
	act_t sumNext;

	// ----------------------------------------
	// multiply-accumulate
	// ----------------------------------------
	always_comb
	begin
		sumNext = Bias;
		for (int i = 0; i < NumInputs; i++)
		begin
			sumNext = sumNext + inReg[i] * Weights[i]; // 16-bit wrap.
		end
	end

	// ----------------------------------------
	// pipeline: inputs, sum, relu
	// ----------------------------------------
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			inReg <= '0;
			sumReg <= '0;
			activation <= '0;
		end
		else
		begin
			inReg <= inputs; // edge 1.
			sumReg <= sumNext; // edge 2.
			if (sumReg[15])
			begin
				activation <= '0; // negative clamps to zero.
			end
			else
			begin
				activation <= sumReg; // edge 3.
			end
		end
	end

endmodule

// ==== hw/denseLayer.sv ====
`timescale 1ns/1ps

module denseLayer #(
	parameter int NumInputs = 10,
	parameter int NumNodes = 4,
	parameter nnPkg::act_t [0:NumNodes-1][0:NumInputs-1] Weights = '0,
	parameter nnPkg::act_t [0:NumNodes-1] Biases = '0
) (
	input logic clk,
	input logic reset,
	input nnPkg::layerIo_t layerIn,
	output nnPkg::layerIo_t layerOut
);
	import nnPkg::*;

	act_t [NumNodes-1:0] nodeOut;
	logic [2:0] validPipe;

	genvar n;
	generate
		for (n = 0; n < NumNodes; n++)
		begin : gNode
			neuronNode #(
				.NumInputs(NumInputs),
				.Weights(Weights[n]),
				.Bias(Biases[n])
			) node (
				.clk(clk),
				.reset(reset),
				.inputs(layerIn.data[NumInputs-1:0]),
				.activation(nodeOut[n])
			);
		end
	endgenerate

	// valid follows the three neuron stages.
	always_ff @(posedge clk)
	begin
		if (reset)
			validPipe <= '0;
		else
			validPipe <= {validPipe[1:0], layerIn.valid};
	end

	always_comb
	begin
		layerOut = '0;
		layerOut.valid = validPipe[2];
		layerOut.data[NumNodes-1:0] = nodeOut; // upper slots stay zero.
	end

endmodule

// ==== hw/apbRegs.sv ====
`timescale 1ns/1ps

module apbRegs (
	input logic clk,
	input logic reset,
	input logic [7:0] paddr,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	output nnPkg::layerIo_t hidIn,
	input nnPkg::layerIo_t netOut
);
	import nnPkg::*;

	inVec_t inRegs;
	outVec_t results;
	nnStatus_t status;
	logic startPulse;

	logic access;
	logic aligned;
	logic [7:0] inOff;
	logic [7:0] outOff;
	logic [3:0] inIdx;
	logic [3:0] outIdx;
	logic isIn;
	logic isCtrl;
	logic isStatus;
	logic isOut;
	logic err;
	logic wrOk;
	logic start;

	// ----------------------------------------
	// address decode
	// ----------------------------------------
	assign access = psel && penable;
	assign aligned = (paddr[1:0] == 2'b00);
	assign inOff = paddr - InBase;
	assign outOff = paddr - OutBase;
	assign inIdx = inOff[5:2];
	assign outIdx = outOff[5:2];

	assign isIn = aligned && (inOff < 8'(NumIn * 4));
	assign isOut = aligned && (outOff < 8'(NumOut * 4));
	assign isCtrl = (paddr == CtrlAddr);
	assign isStatus = (paddr == StatusAddr);

	always_comb
	begin
		err = 1'b0;
		if (!(isIn || isCtrl || isStatus || isOut))
			err = 1'b1; // unmapped.
		else if (pwrite && (isStatus || isOut))
			err = 1'b1; // read-only.
		else if (pwrite && (isIn || isCtrl) && status.busy)
			err = 1'b1; // inference running.
	end

	assign pready = 1'b1;
	assign pslverr = access && err;
	assign wrOk = access && pwrite && !err;
	assign start = wrOk && isCtrl && pwdata[0];

	// ----------------------------------------
	// registers
	// ----------------------------------------
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			inRegs <= '0;
			results <= '0;
			status <= '0;
			startPulse <= 1'b0;
		end
		else
		begin
			startPulse <= start;
			if (wrOk && isIn)
				inRegs[inIdx] <= pwdata[15:0];
			if (start)
			begin
				status.busy <= 1'b1;
				status.done <= 1'b0;
			end
			else if (netOut.valid)
			begin
				status.busy <= 1'b0;
				status.done <= 1'b1;
			end
			if (netOut.valid)
				results <= netOut.data[NumOut-1:0]; // capture at edge 7.
		end
	end

	// inputs are held stable while busy, so the layers see them directly.
	always_comb
	begin
		hidIn.valid = startPulse;
		hidIn.data = inRegs;
	end

	// ----------------------------------------
	// read mux
	// ----------------------------------------
	always_comb
	begin
		prdata = '0;
		if (isIn)
			prdata = {16'h0000, inRegs[inIdx]};
		else if (isStatus)
			prdata = {30'd0, status};
		else if (isOut)
			prdata = {16'h0000, results[outIdx]};
	end

endmodule

// ==== hw/nnTop.sv ====
`timescale 1ns/1ps

module nnTop #(
	parameter nnPkg::act_t [0:nnPkg::NumHidden-1][0:nnPkg::NumIn-1] HiddenWeights =
		nnPkg::HiddenWeights,
	parameter nnPkg::act_t [0:nnPkg::NumHidden-1] HiddenBias = nnPkg::HiddenBias,
	parameter nnPkg::act_t [0:nnPkg::NumOut-1][0:nnPkg::NumHidden-1] OutWeights =
		nnPkg::OutWeights,
	parameter nnPkg::act_t [0:nnPkg::NumOut-1] OutBias = nnPkg::OutBias
) (
	input logic clk,
	input logic reset,
	input logic [7:0] paddr,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr
);
	import nnPkg::*;

	layerIo_t hidIn;
	layerIo_t hidOut;
	layerIo_t netOut;

	apbRegs regs (
		.clk(clk),
		.reset(reset),
		.paddr(paddr),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.hidIn(hidIn),
		.netOut(netOut)
	);

	// 10 inputs to 4 hidden neurons, then 4 to 2.
	denseLayer #(
		.NumInputs(NumIn),
		.NumNodes(NumHidden),
		.Weights(HiddenWeights),
		.Biases(HiddenBias)
	) hiddenLayer (
		.clk(clk),
		.reset(reset),
		.layerIn(hidIn),
		.layerOut(hidOut)
	);

	denseLayer #(
		.NumInputs(NumHidden),
		.NumNodes(NumOut),
		.Weights(OutWeights),
		.Biases(OutBias)
	) outputLayer (
		.clk(clk),
		.reset(reset),
		.layerIn(hidOut),
		.layerOut(netOut)
	);

endmodule

// ==== testbench/nnTb.sv ====
`timescale 1ns/1ps

module nnTb;
	import nnPkg::*;

	localparam int ClkPeriod = 100;
	localparam int MaxPolls = 20;

	logic clk;
	logic reset;
	logic [7:0] paddr;
	logic psel;
	logic penable;
	logic pwrite;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;

	inVec_t vecs[$];
	outVec_t exps[$];
	int numTests;
	bit loaded;
	int errCount;
	int testCount;
	int testFails;
	int testStartErrs;
	logic [31:0] lcgState;

	nnTop uut (
		.clk(clk),
		.reset(reset),
		.paddr(paddr),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr)
	);

	always #(ClkPeriod / 2) clk = ~clk;

	function automatic logic [31:0] nextRand();
		lcgState = lcgState * 32'd1103515245 + 32'd12345;
		return lcgState;
	endfunction

	// ----------------------------------------
	// compare tasks
	// ----------------------------------------
	task automatic checkAct(input string what, input act_t got, input act_t exp);
		if (got !== exp)
		begin
			errCount++;
			$display("** Error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic checkStatus(input string what, input nnStatus_t got, input nnStatus_t exp);
		if (got !== exp)
		begin
			errCount++;
			$display("** Error at %0d ns: %s is busy %b done %b, expected busy %b done %b",
				$time, what, got.busy, got.done, exp.busy, exp.done);
		end
	endtask

	task automatic checkErr(input string what, input bit got, input bit exp);
		if (got !== exp)
		begin
			errCount++;
			$display("** Error at %0d ns: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic endTest(input string name);
		testCount++;
		if (errCount == testStartErrs)
			$display("test %0d (%s) passed", testCount, name);
		else
		begin
			testFails++;
			$display("test %0d (%s) failed, %0d errors", testCount, name, errCount - testStartErrs);
		end
		testStartErrs = errCount;
	endtask

	// ----------------------------------------
	// APB driver
	// ----------------------------------------
	// called 1 ns after a rising edge, takes two cycles.
	task automatic transfer(input logic [7:0] addr, input bit write, input logic [31:0] data,
		output logic [31:0] rdata, output bit err, output bit ready);
		paddr = addr;
		pwrite = write;
		pwdata = data;
		psel = 1'b1;
		penable = 1'b0;
		@(posedge clk);
		#1;
		penable = 1'b1;
		@(negedge clk); // access phase has settled.
		rdata = prdata;
		err = pslverr;
		ready = pready;
		@(posedge clk);
		#1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic writeReg(input logic [7:0] addr, input logic [31:0] data, input bit expErr);
		logic [31:0] unused;
		bit err;
		bit ready;
		transfer(addr, 1'b1, data, unused, err, ready);
		checkErr($sformatf("pslverr on write to %h", addr), err, expErr);
		checkErr($sformatf("pready on write to %h", addr), ready, 1'b1);
	endtask

	task automatic readReg(input logic [7:0] addr, input bit expErr, output logic [31:0] data);
		bit err;
		bit ready;
		transfer(addr, 1'b0, 32'd0, data, err, ready);
		checkErr($sformatf("pslverr on read of %h", addr), err, expErr);
		checkErr($sformatf("pready on read of %h", addr), ready, 1'b1);
	endtask

	task automatic startInference(input inVec_t vec);
		for (int i = 0; i < NumIn; i++)
			writeReg(InBase + 8'(4 * i), {16'h0000, vec[i]}, 1'b0);
		writeReg(CtrlAddr, 32'd1, 1'b0);
	endtask

	task automatic pollDone();
		logic [31:0] rd;
		nnStatus_t st;
		int polls;
		st = '0;
		polls = 0;
		while (!st.done && polls < MaxPolls)
		begin
			readReg(StatusAddr, 1'b0, rd);
			st = rd[1:0];
			polls++;
		end
		if (!st.done)
		begin
			errCount++;
			$display("done was still low after %0d status reads at %0d ns", polls, $time);
		end
	endtask

	task automatic checkResults(input outVec_t exp);
		logic [31:0] rd;
		readReg(OutBase, 1'b0, rd);
		checkAct("result 0", rd[15:0], exp[0]);
		readReg(OutBase + 8'd4, 1'b0, rd);
		checkAct("result 1", rd[15:0], exp[1]);
	endtask

	// lines starting with # are column notes.
	task automatic loadStim();
		int fd;
		int code;
		string line;
		logic [15:0] v [0:11];
		inVec_t vec;
		outVec_t exp;
		fd = $fopen("testbench/nnStim.txt", "r");
		if (fd == 0)
			$display("could not open testbench/nnStim.txt");
		else
		begin
			while (!$feof(fd))
			begin
				code = $fgets(line, fd);
				if (code > 0 && line.len() > 1 && line[0] != "#")
				begin
					code = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h",
						v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9], v[10], v[11]);
					if (code == 12)
					begin
						for (int i = 0; i < NumIn; i++)
							vec[i] = v[i];
						exp[0] = v[10];
						exp[1] = v[11];
						vecs.push_back(vec);
						exps.push_back(exp);
					end
				end
			end
			$fclose(fd);
		end
	endtask

	// ----------------------------------------
	// test sequence
	// ----------------------------------------
	task automatic runTests();
		logic [31:0] rd;
		int ia;
		int ib;
		readReg(StatusAddr, 1'b0, rd);
		checkStatus("status after reset", rd[1:0], '0);
		checkResults('0);
		endTest("reset values");

		foreach (vecs[t])
		begin
			startInference(vecs[t]);
			pollDone();
			checkResults(exps[t]);
			endTest($sformatf("stimulus line %0d", t));
		end

		startInference(vecs[0]);
		writeReg(InBase + 8'd8, nextRand(), 1'b1); // input 2 while busy.
		writeReg(CtrlAddr, nextRand() | 32'd1, 1'b1);
		pollDone();
		checkResults(exps[0]);
		readReg(InBase + 8'd8, 1'b0, rd);
		checkAct("input 2 after rejected write", rd[15:0], vecs[0][2]);
		endTest("writes while busy");

		readReg(8'h38, 1'b1, rd);
		writeReg(8'h40, nextRand(), 1'b1);
		writeReg(8'h06, nextRand(), 1'b1); // misaligned.
		writeReg(StatusAddr, 32'h3, 1'b1);
		writeReg(OutBase, nextRand(), 1'b1);
		writeReg(OutBase + 8'd4, nextRand(), 1'b1);
		readReg(StatusAddr, 1'b0, rd);
		checkStatus("status after rejected writes", rd[1:0], nnStatus_t'{done: 1'b1, busy: 1'b0});
		checkResults(exps[0]);
		readReg(InBase + 8'd4, 1'b0, rd);
		checkAct("input 1 after misaligned write", rd[15:0], vecs[0][1]);
		endTest("unmapped and read-only");

		ia = 1 % vecs.size();
		ib = vecs.size() - 1;
		startInference(vecs[ia]);
		pollDone();
		checkResults(exps[ia]);
		startInference(vecs[ib]);
		readReg(StatusAddr, 1'b0, rd);
		checkStatus("status after second start", rd[1:0], nnStatus_t'{done: 1'b0, busy: 1'b1});
		pollDone();
		checkResults(exps[ib]);
		endTest("back-to-back starts");
	endtask

	initial
	begin
		clk = 1'b0;
		reset = 1'b1;
		paddr = '0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		pwdata = '0;
		lcgState = 32'd13;
		errCount = 0;
		testCount = 0;
		testFails = 0;
		testStartErrs = 0;
		loadStim();
		numTests = vecs.size() + 4;
		loaded = 1'b1;
		repeat (2) @(posedge clk);
		#1;
		reset = 1'b0;
		if (vecs.size() == 0)
		begin
			errCount++;
			$display("no stimulus lines were read, nothing was tested");
		end
		else
			runTests();
		$display("%0d tests, %0d failed, %0d errors", testCount, testFails, errCount);
		if (errCount == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

	// watchdog.
	initial
	begin
		wait (loaded);
		#((numTests * 40 + 100) * ClkPeriod);
		$display("timeout: the tests did not finish within %0d clock periods",
			numTests * 40 + 100);
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

// ==== testbench/nnStim.txt ====
# in0 in1 in2 in3 in4 in5 in6 in7 in8 in9 out0 out1, all 16-bit hex
# out0 and out1 follow from the default package weights with ReLU and 16-bit wrap
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 00B7 000C
0001 0001 0001 0001 0001 0001 0001 0001 0001 0001 0741 0000
0064 0000 0000 0000 0000 0000 0000 0000 0000 0000 0F6B 0000
0000 FFCE 0000 0000 0000 0000 0000 0000 0000 0000 1348 0000
0000 0000 0800 0000 0000 0000 0000 0000 0000 0000 0000 6F81
0001 0002 0003 0004 0005 0006 0007 0008 0009 000A 1CC4 05B2
FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF FFFF 0000 000A
0010 0000 0000 0000 0000 0000 0000 0000 0000 1000 36D9 0DA1

// ==== neuralNet.f ====
hw/nnPkg.sv
hw/neuronNode.sv
hw/denseLayer.sv
hw/apbRegs.sv
hw/nnTop.sv
testbench/nnTb.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the neuralNet testbench with Verilator.

cd "$(dirname "$0")" || exit 1
log=sim.log

if ! verilator --binary --timing --top-module nnTb -f neuralNet.f -o simNn; then
	echo "verilator compile failed"
	exit 1
fi

./obj_dir/simNn > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "ERRORS FOUND" "$log"; then
	echo "simulation failed"
	exit 1
fi
if ! grep -q "NO ERRORS" "$log"; then
	echo "simulation ended without a result"
	exit 1
fi
echo "simulation passed"
exit 0
